/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   ////////////////////
   // basic widths

   typedef logic [31:0] word_t;    // data or address word
   typedef logic [4:0]  regbits_t; // register index

   localparam int    NUM_REGS    = 32;
   localparam word_t INSTR_BYTES = 32'd4;

   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      BEQ   = 6'b000100,
      BNE   = 6'b000101,
      ADDIU = 6'b001001,
      SLTI  = 6'b001010,
      ANDI  = 6'b001100,
      ORI   = 6'b001101,
      XORI  = 6'b001110,
      LW    = 6'b100011,
      SW    = 6'b101011,
      HALT  = 6'b111111
   } opcode_t;

   typedef enum logic [5:0] {
      ADDU = 6'b100001,
      SUBU = 6'b100011,
      AND  = 6'b100100,
      OR   = 6'b100101,
      XOR  = 6'b100110,
      SLT  = 6'b101010
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
   } aluop_t;

   typedef enum logic [1:0] {
      FWD_NONE, // register file value
      FWD_MEM,  // ex/mem alu result
      FWD_WB    // mem/wb write-back value
   } fwd_sel_t;

   ////////////////////
   // instruction views

   typedef struct packed {
      opcode_t    opcode;
      regbits_t   rs;
      regbits_t   rt;
      regbits_t   rd;
      logic [4:0] shamt; // not decoded in this subset
      funct_t     funct;
   } r_t;

   typedef struct packed {
      opcode_t     opcode;
      regbits_t    rs;
      regbits_t    rt;
      logic [15:0] imm;
   } i_t;

   typedef union packed {
      r_t r;
      i_t i;
   } instr_u;

   typedef struct packed {
      logic   reg_write;
      logic   mem_read;
      logic   mem_write;
      logic   alu_src_imm; // b operand from immediate
      logic   dest_rt;     // write rt instead of rd
      logic   branch_eq;
      logic   branch_ne;
      logic   halt;
      aluop_t aluop;
   } ctrl_t;

   ////////////////////
   // memory ports

   typedef struct packed {
      logic  ren;
      word_t addr;
   } imem_req_t;

   typedef struct packed {
      logic  ihit;
      word_t load;
   } imem_rsp_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } dmem_req_t;

   typedef struct packed {
      logic  dhit;
      word_t load;
   } dmem_rsp_t;

   ////////////////////
   // pipeline registers

   typedef struct packed {
      logic   valid;
      instr_u instr;
      word_t  npc;
   } ifid_t;

   typedef struct packed {
      logic     valid;
      ctrl_t    ctrl;
      word_t    rdat1;
      word_t    rdat2;
      word_t    imm;
      regbits_t rs;
      regbits_t rt;
      regbits_t dest;
      word_t    btarget;
   } idex_t;

   typedef struct packed {
      logic     valid;
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     halt;
      word_t    alu;
      word_t    store;
      regbits_t dest;
   } exmem_t;

   typedef struct packed {
      logic     valid;
      logic     reg_write;
      logic     mem_read;
      logic     halt;
      word_t    alu;
      word_t    load;
      regbits_t dest;
   } memwb_t;

   // write-back value, shared by wb select and wb forwarding
   function automatic word_t wb_data(memwb_t mw);
      return mw.mem_read ? mw.load : mw.alu;
   endfunction

endpackage

`default_nettype wire

/* fetch/fetch_stage.sv */
`default_nettype none

module fetch_stage #(
   parameter cpu_pkg::word_t PC_INIT = '0
) (
   input  logic               CLK,
   input  logic               nRST,
   input  cpu_pkg::imem_rsp_t imem_rsp_i,
   input  logic               advance_i,
   input  logic               stall_i,
   input  logic               flush_i,
   input  logic               branch_taken_i,
   input  cpu_pkg::word_t     branch_target_i,
   input  logic               halt_seen_i,
   output cpu_pkg::imem_req_t imem_req_o,
   output cpu_pkg::ifid_t     ifid_o
);
   import cpu_pkg::*;

   word_t pc_q;
   word_t pc_seq;  // sequential next pc
   word_t pc_next;
   logic  halted_q; // halt has moved past decode
   logic  halting;
   ifid_t ifid_q;

   assign pc_seq  = pc_q + INSTR_BYTES;
   assign halting = halt_seen_i || halted_q;

   // branch wins, a halt parks the pc
   always_comb begin
      if (branch_taken_i) begin
         pc_next = branch_target_i;
      end else if (halting) begin
         pc_next = pc_q;
      end else begin
         pc_next = pc_seq;
      end
   end

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         pc_q     <= PC_INIT;
         halted_q <= 1'b0;
      end else if (advance_i) begin
         if (flush_i || !stall_i) pc_q <= pc_next; // hold on load-use
         if (halt_seen_i && !flush_i && !stall_i) halted_q <= 1'b1;
      end
   end

   ////////////////////
   // if/id register
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         ifid_q.valid <= 1'b0;
      end else if (advance_i) begin
         if (flush_i) begin
            ifid_q.valid <= 1'b0; // younger than a taken branch
         end else if (!stall_i) begin
            ifid_q.valid <= !halting; // nothing enters behind halt
            ifid_q.instr <= instr_u'(imem_rsp_i.load);
            ifid_q.npc   <= pc_seq;
         end
      end
   end

   assign imem_req_o.ren  = 1'b1;
   assign imem_req_o.addr = pc_q;
   assign ifid_o          = ifid_q;

endmodule

`default_nettype wire

/* decode/register_file.sv */
`default_nettype none

module register_file (
   input  logic              CLK,
   input  logic              nRST,
   input  cpu_pkg::regbits_t rsel1_i,
   input  cpu_pkg::regbits_t rsel2_i,
   input  logic              we_i,
   input  cpu_pkg::regbits_t waddr_i,
   input  cpu_pkg::word_t    wdata_i,
   output cpu_pkg::word_t    rdat1_o,
   output cpu_pkg::word_t    rdat2_o
);
   import cpu_pkg::*;

   word_t regs_q [NUM_REGS];

   // r0 reads zero, a same-cycle write is passed straight through
   function automatic word_t read_port(regbits_t sel);
      if (sel == '0) return '0;
      if (we_i && (waddr_i == sel)) return wdata_i;
      return regs_q[sel];
   endfunction

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < NUM_REGS; i++) regs_q[i] <= '0;
      end else if (we_i && (waddr_i != '0)) begin
         regs_q[waddr_i] <= wdata_i; // writes to r0 dropped
      end
   end

   always_comb begin
      rdat1_o = read_port(rsel1_i);
      rdat2_o = read_port(rsel2_i);
   end

endmodule

`default_nettype wire

/* decode/decode_stage.sv */
`default_nettype none

module decode_stage (
   input  logic              CLK,
   input  logic              nRST,
   input  cpu_pkg::ifid_t    ifid_i,
   input  cpu_pkg::word_t    rdat1_i,
   input  cpu_pkg::word_t    rdat2_i,
   input  logic              advance_i,
   input  logic              stall_i,
   input  logic              flush_i,
   output cpu_pkg::regbits_t rsel1_o,
   output cpu_pkg::regbits_t rsel2_o,
   output logic              halt_seen_o,
   output cpu_pkg::idex_t    idex_o
);
   import cpu_pkg::*;

   instr_u ins;
   ctrl_t  ctrl;
   word_t  imm_ext;
   word_t  btarget;
   logic   zext;  // logical immediates are zero extended
   idex_t  idex_q;

   assign ins = ifid_i.instr;

   ////////////////////
   // control decode
   always_comb begin
      ctrl = '0; // unknown encodings fall out as a no-op
      case (ins.i.opcode)
         RTYPE: begin
            ctrl.reg_write = 1'b1;
            case (ins.r.funct)
               ADDU:    ctrl.aluop = ALU_ADD;
               SUBU:    ctrl.aluop = ALU_SUB;
               AND:     ctrl.aluop = ALU_AND;
               OR:      ctrl.aluop = ALU_OR;
               XOR:     ctrl.aluop = ALU_XOR;
               SLT:     ctrl.aluop = ALU_SLT;
               default: ctrl.reg_write = 1'b0;
            endcase
         end
         ADDIU, ANDI, ORI, XORI, SLTI, LW: begin
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.dest_rt     = 1'b1;
            ctrl.mem_read    = (ins.i.opcode == LW);
            case (ins.i.opcode)
               ANDI:    ctrl.aluop = ALU_AND;
               ORI:     ctrl.aluop = ALU_OR;
               XORI:    ctrl.aluop = ALU_XOR;
               SLTI:    ctrl.aluop = ALU_SLT;
               default: ctrl.aluop = ALU_ADD; // addiu and lw address
            endcase
         end
         SW: begin
            ctrl.mem_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
         end
         BEQ:  ctrl.branch_eq = 1'b1; // compared in execute
         BNE:  ctrl.branch_ne = 1'b1;
         HALT: ctrl.halt      = 1'b1;
         default: ;
      endcase
   end

   assign zext    = (ins.i.opcode == ANDI) || (ins.i.opcode == ORI) || (ins.i.opcode == XORI);
   assign imm_ext = zext ? {16'b0, ins.i.imm} : {{16{ins.i.imm[15]}}, ins.i.imm};
   assign btarget = ifid_i.npc + {imm_ext[29:0], 2'b00}; // word offset from pc+4

   assign rsel1_o     = ins.r.rs;
   assign rsel2_o     = ins.r.rt;
   assign halt_seen_o = ifid_i.valid && (ins.i.opcode == HALT);

   ////////////////////
   // id/ex register
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         idex_q.valid <= 1'b0;
         idex_q.ctrl  <= '0;
      end else if (advance_i) begin
         if (flush_i || stall_i) begin
            idex_q.valid <= 1'b0; // bubble
            idex_q.ctrl  <= '0;
         end else begin
            idex_q.valid <= ifid_i.valid;
            idex_q.ctrl  <= ifid_i.valid ? ctrl : '0;
         end
         idex_q.rdat1   <= rdat1_i;
         idex_q.rdat2   <= rdat2_i;
         idex_q.imm     <= imm_ext;
         idex_q.rs      <= ins.r.rs;
         idex_q.rt      <= ins.r.rt;
         idex_q.dest    <= ctrl.dest_rt ? ins.r.rt : ins.r.rd;
         idex_q.btarget <= btarget;
      end
   end

   assign idex_o = idex_q;

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`default_nettype none

module execute_stage (
   input  logic              CLK,
   input  logic              nRST,
   input  cpu_pkg::idex_t    idex_i,
   input  cpu_pkg::memwb_t   memwb_i,
   input  cpu_pkg::fwd_sel_t fwd_a_i,
   input  cpu_pkg::fwd_sel_t fwd_b_i,
   input  logic              advance_i,
   output logic              branch_taken_o,
   output cpu_pkg::word_t    branch_target_o,
   output cpu_pkg::exmem_t   exmem_o
);
   import cpu_pkg::*;

   word_t  op_a;
   word_t  fwd_b; // forwarded rt, also the store data
   word_t  op_b;
   word_t  alu_out;
   logic   equal;
   exmem_t exmem_q;

   ////////////////////
   // operand muxes
   function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val);
      case (sel)
         FWD_MEM: return exmem_q.alu; // loads never forward from here
         FWD_WB:  return wb_data(memwb_i);
         default: return reg_val;
      endcase
   endfunction

   always_comb begin
      op_a  = fwd_mux(fwd_a_i, idex_i.rdat1);
      fwd_b = fwd_mux(fwd_b_i, idex_i.rdat2);
   end

   assign op_b = idex_i.ctrl.alu_src_imm ? idex_i.imm : fwd_b;

   ////////////////////
   // alu
   always_comb begin
      case (idex_i.ctrl.aluop)
         ALU_ADD: alu_out = op_a + op_b;
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         ALU_OR:  alu_out = op_a | op_b;
         ALU_XOR: alu_out = op_a ^ op_b;
         ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)}; // signed compare
         default: alu_out = '0;
      endcase
   end

   // branch resolved here, fetch redirects on the same advance
   assign equal           = (op_a == fwd_b);
   assign branch_taken_o  = idex_i.valid &&
                            ((idex_i.ctrl.branch_eq && equal) ||
                             (idex_i.ctrl.branch_ne && !equal));
   assign branch_target_o = idex_i.btarget;

   ////////////////////
   // ex/mem register
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         exmem_q.valid     <= 1'b0;
         exmem_q.reg_write <= 1'b0;
         exmem_q.mem_read  <= 1'b0;
         exmem_q.mem_write <= 1'b0;
         exmem_q.halt      <= 1'b0;
      end else if (advance_i) begin
         exmem_q.valid     <= idex_i.valid;
         exmem_q.reg_write <= idex_i.valid && idex_i.ctrl.reg_write;
         exmem_q.mem_read  <= idex_i.valid && idex_i.ctrl.mem_read;
         exmem_q.mem_write <= idex_i.valid && idex_i.ctrl.mem_write;
         exmem_q.halt      <= idex_i.valid && idex_i.ctrl.halt;
         exmem_q.alu       <= alu_out; // also the data address
         exmem_q.store     <= fwd_b;
         exmem_q.dest      <= idex_i.dest;
      end
   end

   assign exmem_o = exmem_q;

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
`default_nettype none

module hazard_unit (
   input  cpu_pkg::regbits_t  rs_i, // decode sources
   input  cpu_pkg::regbits_t  rt_i,
   input  cpu_pkg::idex_t     idex_i,
   input  cpu_pkg::exmem_t    exmem_i,
   input  cpu_pkg::memwb_t    memwb_i,
   input  cpu_pkg::imem_rsp_t imem_rsp_i,
   input  cpu_pkg::dmem_rsp_t dmem_rsp_i,
   input  logic               branch_taken_i,
   output logic               advance_o,
   output logic               stall_o,
   output logic               flush_o,
   output cpu_pkg::fwd_sel_t  fwd_a_o,
   output cpu_pkg::fwd_sel_t  fwd_b_o
);
   import cpu_pkg::*;

   logic data_access; // ex/mem entry waits on the data port

   // nearest producer wins
   function automatic fwd_sel_t pick_fwd(regbits_t src);
      if (exmem_i.valid && exmem_i.reg_write && (exmem_i.dest != '0) &&
          (exmem_i.dest == src)) return FWD_MEM;
      if (memwb_i.valid && memwb_i.reg_write && (memwb_i.dest != '0) &&
          (memwb_i.dest == src)) return FWD_WB;
      return FWD_NONE;
   endfunction

   always_comb begin
      fwd_a_o = pick_fwd(idex_i.rs);
      fwd_b_o = pick_fwd(idex_i.rt);
   end

   // whole pipe freezes until both ports answer
   assign data_access = exmem_i.valid && (exmem_i.mem_read || exmem_i.mem_write);
   assign advance_o   = imem_rsp_i.ihit && (!data_access || dmem_rsp_i.dhit);

   // load-use, one bubble
   assign stall_o = idex_i.valid && idex_i.ctrl.mem_read && (idex_i.dest != '0) &&
                    ((idex_i.dest == rs_i) || (idex_i.dest == rt_i));

   assign flush_o = branch_taken_i; // kill the two younger slots

endmodule

`default_nettype wire

/* design/mem_wb_stage.sv */
`default_nettype none

module mem_wb_stage (
   input  logic               CLK,
   input  logic               nRST,
   input  cpu_pkg::exmem_t    exmem_i,
   input  cpu_pkg::dmem_rsp_t dmem_rsp_i,
   input  logic               advance_i,
   output cpu_pkg::memwb_t    memwb_o,
   output logic               we_o,
   output cpu_pkg::regbits_t  waddr_o,
   output cpu_pkg::word_t     wdata_o,
   output logic               halt_o
);
   import cpu_pkg::*;

   memwb_t memwb_q;
   logic   halt_q;

   ////////////////////
   // mem/wb register
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         memwb_q.valid     <= 1'b0;
         memwb_q.reg_write <= 1'b0;
         memwb_q.mem_read  <= 1'b0;
         memwb_q.halt      <= 1'b0;
      end else if (advance_i) begin
         memwb_q.valid     <= exmem_i.valid;
         memwb_q.reg_write <= exmem_i.reg_write;
         memwb_q.mem_read  <= exmem_i.mem_read;
         memwb_q.halt      <= exmem_i.halt;
         memwb_q.alu       <= exmem_i.alu;
         memwb_q.load      <= dmem_rsp_i.load; // only meaningful for loads
         memwb_q.dest      <= exmem_i.dest;
      end
   end

   // sticky, set as halt leaves write-back
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         halt_q <= 1'b0;
      end else if (advance_i && memwb_q.valid && memwb_q.halt) begin
         halt_q <= 1'b1;
      end
   end

   assign we_o    = memwb_q.valid && memwb_q.reg_write;
   assign waddr_o = memwb_q.dest;
   assign wdata_o = wb_data(memwb_q); // load or alu result
   assign memwb_o = memwb_q;
   assign halt_o  = halt_q;

endmodule

`default_nettype wire

/* design/datapath.sv */
`default_nettype none

module datapath #(
   parameter cpu_pkg::word_t PC_INIT = '0
) (
   input  logic               CLK,
   input  logic               nRST,
   input  cpu_pkg::imem_rsp_t imem_rsp_i,
   output cpu_pkg::imem_req_t imem_req_o,
   input  cpu_pkg::dmem_rsp_t dmem_rsp_i,
   output cpu_pkg::dmem_req_t dmem_req_o,
   output logic               halt_o
);
   import cpu_pkg::*;

   ifid_t    ifid;
   idex_t    idex;
   exmem_t   exmem;
   memwb_t   memwb;
   regbits_t rsel1, rsel2;
   word_t    rdat1, rdat2;
   logic     we;
   regbits_t waddr;
   word_t    wdata;
   logic     halt_seen;
   logic     branch_taken;
   word_t    branch_target;
   logic     advance, stall, flush;
   fwd_sel_t fwd_a, fwd_b;

   // data port straight off ex/mem
   assign dmem_req_o.ren   = exmem.mem_read;
   assign dmem_req_o.wen   = exmem.mem_write;
   assign dmem_req_o.addr  = exmem.alu;
   assign dmem_req_o.store = exmem.store;

   fetch_stage #(.PC_INIT(PC_INIT)) u_fetch (
      .CLK, .nRST, .imem_rsp_i,
      .advance_i(advance), .stall_i(stall), .flush_i(flush),
      .branch_taken_i(branch_taken), .branch_target_i(branch_target),
      .halt_seen_i(halt_seen), .imem_req_o, .ifid_o(ifid)
   );

   decode_stage u_decode (
      .CLK, .nRST, .ifid_i(ifid), .rdat1_i(rdat1), .rdat2_i(rdat2),
      .advance_i(advance), .stall_i(stall), .flush_i(flush),
      .rsel1_o(rsel1), .rsel2_o(rsel2), .halt_seen_o(halt_seen), .idex_o(idex)
   );

   register_file u_regs (
      .CLK, .nRST, .rsel1_i(rsel1), .rsel2_i(rsel2),
      .we_i(we), .waddr_i(waddr), .wdata_i(wdata),
      .rdat1_o(rdat1), .rdat2_o(rdat2)
   );

   execute_stage u_execute (
      .CLK, .nRST, .idex_i(idex), .memwb_i(memwb),
      .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .advance_i(advance),
      .branch_taken_o(branch_taken), .branch_target_o(branch_target),
      .exmem_o(exmem)
   );

   mem_wb_stage u_mem_wb (
      .CLK, .nRST, .exmem_i(exmem), .dmem_rsp_i, .advance_i(advance),
      .memwb_o(memwb), .we_o(we), .waddr_o(waddr), .wdata_o(wdata), .halt_o
   );

   hazard_unit u_hazard (
      .rs_i(rsel1), .rt_i(rsel2), .idex_i(idex), .exmem_i(exmem), .memwb_i(memwb),
      .imem_rsp_i, .dmem_rsp_i, .branch_taken_i(branch_taken),
      .advance_o(advance), .stall_o(stall), .flush_o(flush),
      .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
   );

endmodule

`default_nettype wire

/* dv/datapath_checker.sv */
`default_nettype none

module datapath_checker (
   input logic               CLK,
   input logic               nRST,
   input cpu_pkg::imem_req_t imem_req_i,
   input cpu_pkg::imem_rsp_t imem_rsp_i,
   input cpu_pkg::dmem_req_t dmem_req_i,
   input cpu_pkg::dmem_rsp_t dmem_rsp_i,
   input logic               halt_i
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0; // polled by the testbench every cycle

   ////////////////////
   // memory ports

   // fetch address held until ihit
   imem_held: assert property (@(posedge CLK) disable iff (!nRST)
      imem_req_i.ren && !imem_rsp_i.ihit |=> $stable(imem_req_i))
      else begin
         $error("instruction request changed before its hit");
         fail_count++;
      end

   // whole data request held until dhit
   dmem_held: assert property (@(posedge CLK) disable iff (!nRST)
      (dmem_req_i.ren || dmem_req_i.wen) && !dmem_rsp_i.dhit |=> $stable(dmem_req_i))
      else begin
         $error("data request changed before its hit");
         fail_count++;
      end

   dmem_one_op: assert property (@(posedge CLK) disable iff (!nRST)
      !(dmem_req_i.ren && dmem_req_i.wen))
      else begin
         $error("data read and write requested together");
         fail_count++;
      end

   ////////////////////
   // halt is sticky until reset
   halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      halt_i |=> halt_i)
      else begin
         $error("halt output fell without reset");
         fail_count++;
      end

endmodule

bind datapath datapath_checker chk (
   .CLK, .nRST,
   .imem_req_i(imem_req_o), .imem_rsp_i,
   .dmem_req_i(dmem_req_o), .dmem_rsp_i,
   .halt_i(halt_o)
);

`default_nettype wire

/* dv/datapath_tb.sv */
`default_nettype none

module datapath_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import cpu_pkg::*;

   localparam int          IMEM_WORDS   = 64;
   localparam int          DMEM_WORDS   = 256;
   localparam int          RESET_CYCLES = 10;
   localparam int          MAX_CYCLES   = 5 * 40 * 8 + 5 * RESET_CYCLES; // programs x instr x cycles
   localparam word_t       LOAD_ADDR    = 32'h0000_0080;
   localparam logic [31:0] SEED         = 32'h4847_f15d;

   logic      CLK;
   logic      nRST;
   imem_req_t imem_req;
   imem_rsp_t imem_rsp;
   dmem_req_t dmem_req;
   dmem_rsp_t dmem_rsp;
   logic      halt;

   word_t       imem [IMEM_WORDS];
   word_t       dmem [DMEM_WORDS];
   word_t       prog [$];     // program being built
   word_t       chk_addr [$]; // data words to compare after halt
   word_t       chk_exp [$];
   logic [15:0] next_slot;    // next result address for store_reg

   datapath #(.PC_INIT(32'h0000_0000)) dut (
      .CLK, .nRST,
      .imem_rsp_i(imem_rsp), .imem_req_o(imem_req),
      .dmem_rsp_i(dmem_rsp), .dmem_req_o(dmem_req),
      .halt_o(halt)
   );

   initial begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK; // 4 ns period
   end

   ////////////////////
   // memory models, 0 to 2 wait cycles per new request
   initial begin
      imem_req_t last_i;
      dmem_req_t last_d;
      int unsigned wait_i;
      int unsigned wait_d;
      void'($urandom(SEED));
      last_i = '0;
      last_d = '0;
      wait_i = 0;
      wait_d = 0;
      forever begin
         @(posedge CLK);
         #1;
         if (imem_req !== last_i) begin // new fetch address
            wait_i = $urandom % 3;
            last_i = imem_req;
         end
         imem_rsp.ihit = imem_req.ren && (wait_i == 0);
         imem_rsp.load = imem[imem_req.addr[7:2]];
         if (wait_i != 0) wait_i--;
         if (!(dmem_req.ren || dmem_req.wen)) begin
            dmem_rsp.dhit = 1'b0;
            last_d        = dmem_req;
         end else begin
            if (dmem_req !== last_d) begin
               wait_d = $urandom % 3;
               last_d = dmem_req;
            end
            dmem_rsp.dhit = (wait_d == 0);
            if (wait_d != 0) begin
               wait_d--;
            end else if (dmem_req.wen) begin
               dmem[dmem_req.addr[9:2]] = dmem_req.store; // write lands with dhit
            end
         end
         dmem_rsp.load = dmem[dmem_req.addr[9:2]];
      end
   end

   ////////////////////
   // watchdog and assertion monitor
   initial begin
      int unsigned cycles;
      cycles = 0;
      forever begin
         @(negedge CLK);
         cycles++;
         if (dut.chk.fail_count != 0) begin
            $display("A port or halt assertion failed at %0t", $time);
            $display("Something failed");
            $fatal(1, "assertion failure");
         end else if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $fatal(1, "timeout");
         end
      end
   end

   task automatic check(string name, word_t got, word_t exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("Something failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // instruction encoding
   function automatic word_t r_op(funct_t f, regbits_t rd, regbits_t rs, regbits_t rt);
      return {RTYPE, rs, rt, rd, 5'd0, f};
   endfunction

   function automatic word_t i_op(opcode_t op, regbits_t rt, regbits_t rs, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t sext16(logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   function automatic word_t fill_word(word_t addr);
      return 32'h5a5a_0000 ^ addr; // untouched data words
   endfunction

   task automatic emit(word_t w);
      prog.push_back(w);
   endtask

   task automatic expect_word(word_t addr, word_t exp);
      chk_addr.push_back(addr);
      chk_exp.push_back(exp);
   endtask

   // sw rt to the next result slot
   task automatic store_reg(regbits_t rt, word_t exp);
      emit(i_op(SW, rt, 0, next_slot));
      expect_word({16'b0, next_slot}, exp);
      next_slot += 16'd4;
   endtask

   task automatic dead_store(regbits_t rt); // must never reach memory
      emit(i_op(SW, rt, 0, next_slot));
      expect_word({16'b0, next_slot}, fill_word({16'b0, next_slot}));
      next_slot += 16'd4;
   endtask

   task automatic alu_result(word_t ins, regbits_t rd, word_t exp);
      emit(ins);
      store_reg(rd, exp);
   endtask

   task automatic begin_program();
      @(posedge CLK);
      #1 nRST = 1'b0;
      prog.delete();
      chk_addr.delete();
      chk_exp.delete();
      next_slot = 16'h0100;
      for (int i = 0; i < IMEM_WORDS; i++) imem[i] = {HALT, 26'(i * 4)}; // spare slots halt
      for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = fill_word(32'(i * 4));
   endtask

   task automatic compare_results();
      foreach (chk_addr[i]) begin
         check($sformatf("dmem[%h]", chk_addr[i]), dmem[chk_addr[i][9:2]], chk_exp[i]);
      end
   endtask

   task automatic run_until_halt();
      foreach (prog[i]) imem[i] = prog[i];
      repeat (RESET_CYCLES) @(posedge CLK);
      #1 nRST = 1'b1;
      do @(negedge CLK); while (!halt);
      compare_results();
   endtask

   ////////////////////
   // directed tests

   task automatic alu_operations();
      word_t a;
      word_t b;
      a = 32'h0000_7ff3;
      b = sext16(16'hfffb);
      begin_program();
      emit(i_op(ADDIU, 1, 0, 16'h7ff3));
      emit(i_op(ADDIU, 2, 0, 16'hfffb)); // negative
      alu_result(r_op(ADDU, 3, 1, 2), 3, a + b);
      alu_result(r_op(SUBU, 4, 1, 2), 4, a - b);
      alu_result(r_op(AND, 5, 1, 2), 5, a & b);
      alu_result(r_op(OR, 6, 1, 2), 6, a | b);
      alu_result(r_op(XOR, 7, 1, 2), 7, a ^ b);
      alu_result(r_op(SLT, 8, 2, 1), 8, 32'd1); // -5 below 32755
      alu_result(r_op(SLT, 9, 1, 2), 9, 32'd0);
      alu_result(i_op(ADDIU, 10, 1, 16'h8001), 10, a + sext16(16'h8001));
      alu_result(i_op(ANDI, 11, 2, 16'h8f0f), 11, b & 32'h0000_8f0f); // zero extended
      alu_result(i_op(ORI, 12, 2, 16'h00f0), 12, b | 32'h0000_00f0);
      alu_result(i_op(XORI, 13, 1, 16'hffff), 13, a ^ 32'h0000_ffff);
      alu_result(i_op(SLTI, 14, 2, 16'hfffd), 14, 32'd1); // -5 below -3
      emit(i_op(HALT, 0, 0, 16'h0000));
      run_until_halt();
   endtask

   task automatic forwarding_paths();
      word_t r2_val;
      word_t r4_val;
      r2_val = 32'd11 + 32'd11;
      r4_val = r2_val - 32'd3;
      begin_program();
      emit(i_op(ADDIU, 1, 0, 16'd11));
      emit(r_op(ADDU, 2, 1, 1));      // distance 1 on both operands
      emit(i_op(ADDIU, 3, 0, 16'd3));
      emit(i_op(ADDIU, 9, 0, 16'd0)); // spacer
      emit(r_op(SUBU, 4, 2, 3));      // r2 at distance 3, r3 at 2
      store_reg(4, r4_val);           // store data at distance 1
      emit(r_op(ADDU, 5, 4, 1));      // r4 at distance 2
      store_reg(5, r4_val + 32'd11);
      emit(i_op(ADDIU, 7, 0, 16'd1));
      emit(i_op(ADDIU, 7, 7, 16'd2));
      emit(i_op(ADDIU, 7, 7, 16'd4));
      store_reg(7, 32'd7);
      emit(i_op(ADDIU, 6, 0, 16'h0180)); // base register forwarded
      emit(i_op(SW, 2, 6, 16'h0000));
      expect_word(32'h0000_0180, r2_val);
      emit(i_op(HALT, 0, 0, 16'h0000));
      run_until_halt();
   endtask

   task automatic load_use_stall();
      word_t ld;
      ld = 32'h1357_9bdf;
      begin_program();
      dmem[LOAD_ADDR[9:2]] = ld;
      emit(i_op(ADDIU, 1, 0, 16'h0055));
      emit(i_op(LW, 2, 0, LOAD_ADDR[15:0]));
      emit(r_op(ADDU, 3, 2, 1)); // rs waits one bubble
      store_reg(3, ld + 32'h55);
      emit(i_op(LW, 4, 0, LOAD_ADDR[15:0]));
      store_reg(4, ld);          // store data straight off the load
      emit(i_op(LW, 5, 0, LOAD_ADDR[15:0]));
      emit(r_op(SUBU, 6, 1, 5)); // rt side
      store_reg(6, 32'h55 - ld);
      emit(i_op(HALT, 0, 0, 16'h0000));
      run_until_halt();
   endtask

   task automatic branch_flush();
      begin_program();
      emit(i_op(ADDIU, 1, 0, 16'd5));
      emit(i_op(ADDIU, 2, 0, 16'd5));
      emit(i_op(BEQ, 2, 1, 16'd2)); // taken
      dead_store(1);
      dead_store(1);
      emit(i_op(ADDIU, 3, 0, 16'd9));
      emit(i_op(BNE, 3, 1, 16'd2)); // taken, r3 forwarded
      dead_store(1);
      dead_store(1);
      emit(i_op(BEQ, 3, 1, 16'd1)); // falls through
      store_reg(3, 32'd9);
      emit(i_op(BNE, 2, 1, 16'd1)); // falls through
      store_reg(2, 32'd5);
      emit(i_op(HALT, 0, 0, 16'h0000));
      run_until_halt();
   endtask

   task automatic halt_behavior();
      begin_program();
      emit(i_op(ADDIU, 0, 0, 16'h0077)); // r0 write is dropped
      emit(i_op(ADDIU, 1, 0, 16'h0033));
      store_reg(0, 32'd0);
      store_reg(1, 32'h0000_0033);
      emit(i_op(HALT, 0, 0, 16'h0000));
      dead_store(1);                     // behind halt
      dead_store(1);
      run_until_halt();
      repeat (20) @(negedge CLK);
      check("halt_o", {31'b0, halt}, 32'd1);
      compare_results();                 // late stores would show up here
   endtask

   initial begin
      nRST     = 1'b0;
      imem_rsp = '0;
      dmem_rsp = '0;
      alu_operations();
      forwarding_paths();
      load_use_stall();
      branch_flush();
      halt_behavior();
      if (dut.chk.fail_count == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("Something failed");
         $fatal(1, "assertion failures");
      end
   end

endmodule

`default_nettype wire

/* project.f */
common/cpu_pkg.sv
fetch/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
design/hazard_unit.sv
design/mem_wb_stage.sv
design/datapath.sv
dv/datapath_checker.sv
dv/datapath_tb.sv

/* Bender.yml */
package:
  name: pipelined_datapath

sources:
  - common/cpu_pkg.sv
  - fetch/fetch_stage.sv
  - decode/register_file.sv
  - decode/decode_stage.sv
  - execute/execute_stage.sv
  - design/hazard_unit.sv
  - design/mem_wb_stage.sv
  - design/datapath.sv
  - target: test
    files:
      - dv/datapath_checker.sv
      - dv/datapath_tb.sv
